// ==== filelist.f ====
logic/cpu_ctrl_pkg.sv
logic/instr_decoder.sv
logic/hazard_unit.sv
logic/intr_fsm.sv
logic/flush_fsm.sv
logic/pipeline_control.sv
sim/pipeline_control_tb.sv

// ==== logic/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [7:0] instr_t;      // {opcode[7:4], ra[3:2], rb[1:0]}
    typedef logic [1:0] reg_idx_t;
    typedef logic [3:0] sb_entry_t;   // {from_mem, writes, dest[1:0]}

    localparam reg_idx_t  SP_REG   = 2'd3;     // Stack pointer register
    localparam sb_entry_t SB_EMPTY = 4'b0000;  // Bubble, writes nothing

    // ----------------------------------------
    // Instruction and datapath encodings
    // ----------------------------------------
    typedef enum logic [3:0] {
        OPC_NOP   = 4'd0,
        OPC_MOV   = 4'd1,
        OPC_ADD   = 4'd2,
        OPC_SUB   = 4'd3,
        OPC_AND   = 4'd4,
        OPC_OR    = 4'd5,
        OPC_SHIFT = 4'd6,   // RLC, RRC, SETC, CLRC
        OPC_STACK = 4'd7,   // PUSH, POP
        OPC_UNARY = 4'd8,   // NOT, NEG, INC, DEC
        OPC_JCOND = 4'd9,
        OPC_LOOP  = 4'd10,
        OPC_JUMP  = 4'd11   // JMP, CALL, RET, RTI
    } opcode_e;

    // Codes 2 to 5 line up with the opcodes of the two-operand group
    typedef enum logic [3:0] {
        MOV_A = 4'd0,  MOV_B = 4'd1,  ADD  = 4'd2,  SUB  = 4'd3,
        AND   = 4'd4,  OR    = 4'd5,  DEC  = 4'd6,  INC  = 4'd7,
        NEG   = 4'd8,  NOT   = 4'd9,  RLC  = 4'd10, RRC  = 4'd11,
        SETC  = 4'd12, CLRC  = 4'd13, DEC_A = 4'd14
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG = 2'd0,     // Register file read
        SRC_IMM = 2'd1
    } opnd_src_e;

    localparam opnd_src_e SRC_PC = SRC_IMM;  // Same code means PC on operand B

    typedef enum logic [1:0] {
        FWD_ALU  = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2,
        FWD_NONE = 2'd3
    } fwd_sel_e;

    typedef enum logic [1:0] {
        FLG_NONE = 2'd0,
        FLG_ZN   = 2'd1,
        FLG_ALL  = 2'd2
    } flag_chg_e;

    typedef enum logic [2:0] {
        JC_NONE = 3'd0,
        JC_JZ   = 3'd1,
        JC_JN   = 3'd2,
        JC_JC   = 3'd3,
        JC_JV   = 3'd4,
        JC_JMP  = 3'd5,     // JMP and CALL
        JC_RET  = 3'd6,     // RET and RTI
        JC_LOOP = 3'd7
    } jmp_chk_e;

    // ----------------------------------------
    // FSM states
    // ----------------------------------------
    typedef enum logic [1:0] {
        I_NORMAL, I_RISE, I_ACTIVE, I_FALL
    } intr_state_e;

    typedef enum logic [2:0] {
        J_NORMAL, J_UNCOND, J_DELAY1, J_DELAY2, J_COND
    } flush_state_e;

endpackage

`default_nettype wire

// ==== logic/flush_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module flush_fsm (
    input  wire                        clk,
    input  wire                        reset,
    input  wire cpu_ctrl_pkg::jmp_chk_e i_jmp_chk,
    input  wire                        i_stall,
    input  wire                        i_branch_taken,
    output logic                       o_flush_f,
    output logic                       o_flush_d,
    output logic                       o_flush_ex
);

    import cpu_ctrl_pkg::*;

    flush_state_e state;
    flush_state_e state_nxt;
    logic         is_cond;
    logic         is_uncond;
    logic         is_delayed;
    logic         flush_fd;

    assign is_cond    = i_jmp_chk inside {JC_JZ, JC_JN, JC_JC, JC_JV, JC_LOOP};
    assign is_uncond  = (i_jmp_chk == JC_JMP);
    assign is_delayed = (i_jmp_chk == JC_RET);   // Target comes from memory

    always_comb begin
        state_nxt = J_NORMAL;
        case (state)
            J_NORMAL: begin
                if (!i_stall) begin                  // Held jump not taken yet
                    if (is_delayed) begin
                        state_nxt = J_DELAY1;
                    end else if (is_uncond) begin
                        state_nxt = J_UNCOND;
                    end else if (is_cond) begin
                        state_nxt = J_COND;
                    end
                end
            end
            J_DELAY1: state_nxt = J_DELAY2;
            default:  state_nxt = J_NORMAL;         // One flush cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= J_NORMAL;
        end else begin
            state <= state_nxt;
        end
    end

    // ----------------------------------------
    // Flush pulses
    // ----------------------------------------
    assign flush_fd = (state == J_UNCOND) || (state == J_DELAY2) ||
                      ((state == J_COND) && i_branch_taken);

    assign o_flush_f  = flush_fd;
    assign o_flush_d  = flush_fd;
    assign o_flush_ex = (state == J_DELAY2);

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire cpu_ctrl_pkg::reg_idx_t  i_reg_1,
    input  wire cpu_ctrl_pkg::reg_idx_t  i_reg_2,
    input  wire cpu_ctrl_pkg::opnd_src_e i_alu_src_a,
    input  wire cpu_ctrl_pkg::opnd_src_e i_alu_src_b,
    input  wire                         i_reg_write,
    input  wire cpu_ctrl_pkg::reg_idx_t  i_wb_sel,
    input  wire                         i_mem_read,
    output cpu_ctrl_pkg::fwd_sel_e      o_forward_src_a,
    output cpu_ctrl_pkg::fwd_sel_e      o_forward_src_b,
    output logic                        o_stall_f,
    output logic                        o_stall_d
);

    import cpu_ctrl_pkg::*;

    sb_entry_t ex_q;
    sb_entry_t mem_q;
    sb_entry_t wb_q;
    sb_entry_t dc_entry;
    reg_idx_t  src_reg  [2];
    logic      src_rd   [2];
    fwd_sel_e  fwd_sel  [2];
    logic      load_hit [2];
    logic      stall;

    function automatic logic writes_to(sb_entry_t e, reg_idx_t r);
        return e[2] && (e[1:0] == r);
    endfunction

    assign dc_entry   = {i_mem_read, i_reg_write, i_wb_sel};
    assign src_reg[0] = i_reg_1;
    assign src_reg[1] = i_reg_2;
    assign src_rd[0]  = (i_alu_src_a == SRC_REG);
    assign src_rd[1]  = (i_alu_src_b == SRC_REG);

    // ----------------------------------------
    // Youngest writer wins
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            fwd_sel[i]  = FWD_NONE;
            load_hit[i] = 1'b0;
            if (src_rd[i]) begin
                if (writes_to(ex_q, src_reg[i])) begin
                    fwd_sel[i]  = FWD_ALU;
                    load_hit[i] = ex_q[3];  // Load data not ready yet
                end else if (writes_to(mem_q, src_reg[i])) begin
                    fwd_sel[i] = FWD_MEM;
                end else if (writes_to(wb_q, src_reg[i])) begin
                    fwd_sel[i] = FWD_WB;
                end
            end
        end
    end

    assign stall           = load_hit[0] | load_hit[1];
    assign o_stall_f       = stall;
    assign o_stall_d       = stall;
    assign o_forward_src_a = fwd_sel[0];
    assign o_forward_src_b = fwd_sel[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_q  <= SB_EMPTY;
            mem_q <= SB_EMPTY;
            wb_q  <= SB_EMPTY;
        end else begin
            ex_q  <= stall ? SB_EMPTY : dc_entry;   // Bubble on load-use
            mem_q <= ex_q;
            wb_q  <= mem_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire cpu_ctrl_pkg::instr_t  i_instr,
    input  wire                        i_intr_ack,
    output logic                       o_reg_write,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output cpu_ctrl_pkg::alu_op_e      o_alu_op,
    output cpu_ctrl_pkg::flag_chg_e    o_flag_change,
    output cpu_ctrl_pkg::reg_idx_t     o_reg_1,
    output cpu_ctrl_pkg::reg_idx_t     o_reg_2,
    output cpu_ctrl_pkg::opnd_src_e    o_alu_src_a,
    output cpu_ctrl_pkg::opnd_src_e    o_alu_src_b,
    output cpu_ctrl_pkg::reg_idx_t     o_wb_sel,
    output logic                       o_sp_inc,
    output logic                       o_sp_dec,
    output cpu_ctrl_pkg::jmp_chk_e     o_jmp_chk,
    output logic                       o_store_pc,
    output logic                       o_return_flags
);

    import cpu_ctrl_pkg::*;

    opcode_e  opcode;
    reg_idx_t ra;
    reg_idx_t rb;

    assign opcode = opcode_e'(i_instr[7:4]);
    assign ra     = i_instr[3:2];
    assign rb     = i_instr[1:0];

    always_comb begin
        o_reg_write    = 1'b0;
        o_mem_read     = 1'b0;
        o_mem_write    = 1'b0;
        o_alu_op       = MOV_A;
        o_flag_change  = FLG_NONE;
        o_reg_1        = '0;
        o_reg_2        = '0;
        o_alu_src_a    = SRC_IMM;
        o_alu_src_b    = SRC_IMM;
        o_wb_sel       = '0;
        o_sp_inc       = 1'b0;
        o_sp_dec       = 1'b0;
        o_jmp_chk      = JC_NONE;
        o_store_pc     = 1'b0;
        o_return_flags = 1'b0;

        if (i_intr_ack) begin               // Push PC on interrupt entry
            o_alu_src_a = SRC_REG;
            o_alu_src_b = SRC_PC;
            o_reg_1     = SP_REG;
            o_sp_dec    = 1'b1;
            o_mem_write = 1'b1;
        end else begin
            case (opcode)
                OPC_MOV: begin
                    o_alu_op    = MOV_B;
                    o_alu_src_b = SRC_REG;
                    o_reg_2     = rb;
                    o_wb_sel    = ra;
                    o_reg_write = 1'b1;
                end
                OPC_ADD, OPC_SUB, OPC_AND, OPC_OR: begin
                    o_alu_op      = alu_op_e'(opcode);
                    o_flag_change = (opcode inside {OPC_ADD, OPC_SUB}) ? FLG_ALL : FLG_ZN;
                    o_alu_src_a   = SRC_REG;
                    o_alu_src_b   = SRC_REG;
                    o_reg_1       = ra;
                    o_reg_2       = rb;
                    o_wb_sel      = ra;
                    o_reg_write   = 1'b1;
                end
                OPC_SHIFT: begin
                    case (ra)
                        2'd0:    o_alu_op = RLC;
                        2'd1:    o_alu_op = RRC;
                        2'd2:    o_alu_op = SETC;
                        default: o_alu_op = CLRC;
                    endcase
                    if (!ra[1]) begin       // Rotates write rb back
                        o_alu_src_b = SRC_REG;
                        o_reg_2     = rb;
                        o_wb_sel    = rb;
                        o_reg_write = 1'b1;
                    end
                end
                OPC_STACK: begin
                    if (ra == 2'd0) begin   // PUSH
                        o_alu_src_a = SRC_REG;
                        o_alu_src_b = SRC_REG;
                        o_reg_1     = SP_REG;
                        o_reg_2     = rb;
                        o_mem_write = 1'b1;
                        o_sp_dec    = 1'b1;
                    end else if (ra == 2'd1) begin  // POP
                        o_alu_src_a = SRC_REG;
                        o_reg_1     = SP_REG;
                        o_wb_sel    = rb;
                        o_mem_read  = 1'b1;
                        o_reg_write = 1'b1;
                        o_sp_inc    = 1'b1;
                    end
                end
                OPC_UNARY: begin
                    case (ra)
                        2'd0:    o_alu_op = NOT;
                        2'd1:    o_alu_op = NEG;
                        2'd2:    o_alu_op = INC;
                        default: o_alu_op = DEC;
                    endcase
                    o_flag_change = ra[1] ? FLG_ALL : FLG_ZN;  // INC/DEC touch carry
                    o_alu_src_b   = SRC_REG;
                    o_reg_2       = rb;
                    o_wb_sel      = rb;
                    o_reg_write   = 1'b1;
                end
                OPC_JCOND: begin
                    o_jmp_chk   = jmp_chk_e'({1'b0, ra} + 3'd1);  // JZ..JV
                    o_alu_src_b = SRC_REG;
                    o_reg_2     = rb;
                end
                OPC_LOOP: begin
                    o_alu_op    = DEC_A;
                    o_alu_src_a = SRC_REG;
                    o_alu_src_b = SRC_REG;
                    o_reg_1     = ra;
                    o_reg_2     = rb;
                    o_wb_sel    = ra;
                    o_reg_write = 1'b1;
                    o_jmp_chk   = JC_LOOP;
                end
                OPC_JUMP: begin
                    if (!ra[1]) begin       // JMP, CALL
                        o_jmp_chk   = JC_JMP;
                        o_alu_src_b = SRC_REG;
                        o_reg_2     = rb;
                        if (ra[0]) begin    // CALL pushes return PC
                            o_alu_src_a = SRC_REG;
                            o_reg_1     = SP_REG;
                            o_sp_dec    = 1'b1;
                            o_mem_write = 1'b1;
                            o_store_pc  = 1'b1;
                        end
                    end else begin          // RET, RTI
                        o_jmp_chk      = JC_RET;
                        o_alu_src_a    = SRC_REG;
                        o_reg_1        = SP_REG;
                        o_sp_inc       = 1'b1;
                        o_mem_read     = 1'b1;
                        o_return_flags = ra[0];
                    end
                end
                default: ;                  // NOP and unused opcodes
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/intr_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module intr_fsm (
    input  wire  clk,
    input  wire  reset,
    input  wire  i_intr,
    output logic o_intr_ack,
    output logic o_intr_active,
    output logic o_intr_ret
);

    import cpu_ctrl_pkg::*;

    intr_state_e state;
    intr_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            I_NORMAL: if (i_intr) state_nxt = I_RISE;
            I_RISE:   state_nxt = I_ACTIVE;         // Ack lasts one cycle
            I_ACTIVE: if (!i_intr) state_nxt = I_FALL;
            default:  state_nxt = I_NORMAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= I_NORMAL;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_intr_ack    = (state == I_RISE);
    assign o_intr_active = (state == I_ACTIVE);
    assign o_intr_ret    = (state == I_FALL);       // Fetch injects RTI

endmodule

`default_nettype wire

// ==== logic/pipeline_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  wire                        clk,
    input  wire                        reset,
    input  wire cpu_ctrl_pkg::instr_t  i_instr,
    input  wire                        i_branch_taken,
    input  wire                        i_intr,

    // ----------------------------------------
    // Datapath controls
    // ----------------------------------------
    output logic                       o_reg_write,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output cpu_ctrl_pkg::alu_op_e      o_alu_op,
    output cpu_ctrl_pkg::flag_chg_e    o_flag_change,
    output cpu_ctrl_pkg::reg_idx_t     o_reg_1,
    output cpu_ctrl_pkg::reg_idx_t     o_reg_2,
    output cpu_ctrl_pkg::opnd_src_e    o_alu_src_a,
    output cpu_ctrl_pkg::opnd_src_e    o_alu_src_b,
    output cpu_ctrl_pkg::reg_idx_t     o_wb_sel,
    output logic                       o_sp_inc,
    output logic                       o_sp_dec,
    output cpu_ctrl_pkg::jmp_chk_e     o_jmp_chk,
    output logic                       o_store_pc,
    output logic                       o_return_flags,

    // ----------------------------------------
    // Pipeline controls
    // ----------------------------------------
    output cpu_ctrl_pkg::fwd_sel_e     o_forward_src_a,
    output cpu_ctrl_pkg::fwd_sel_e     o_forward_src_b,
    output logic                       o_stall_f,
    output logic                       o_stall_d,
    output logic                       o_flush_f,
    output logic                       o_flush_d,
    output logic                       o_flush_ex,
    output logic                       o_intr_ack,
    output logic                       o_intr_active,
    output logic                       o_intr_ret
);

    instr_decoder instr_decoder_inst (
        .i_instr        (i_instr),
        .i_intr_ack     (o_intr_ack),           // Forces the PC push
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_alu_op       (o_alu_op),
        .o_flag_change  (o_flag_change),
        .o_reg_1        (o_reg_1),
        .o_reg_2        (o_reg_2),
        .o_alu_src_a    (o_alu_src_a),
        .o_alu_src_b    (o_alu_src_b),
        .o_wb_sel       (o_wb_sel),
        .o_sp_inc       (o_sp_inc),
        .o_sp_dec       (o_sp_dec),
        .o_jmp_chk      (o_jmp_chk),
        .o_store_pc     (o_store_pc),
        .o_return_flags (o_return_flags)
    );

    hazard_unit hazard_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .i_reg_1         (o_reg_1),
        .i_reg_2         (o_reg_2),
        .i_alu_src_a     (o_alu_src_a),
        .i_alu_src_b     (o_alu_src_b),
        .i_reg_write     (o_reg_write),
        .i_wb_sel        (o_wb_sel),
        .i_mem_read      (o_mem_read),
        .o_forward_src_a (o_forward_src_a),
        .o_forward_src_b (o_forward_src_b),
        .o_stall_f       (o_stall_f),
        .o_stall_d       (o_stall_d)
    );

    intr_fsm intr_fsm_inst (
        .clk           (clk),
        .reset         (reset),
        .i_intr        (i_intr),
        .o_intr_ack    (o_intr_ack),
        .o_intr_active (o_intr_active),
        .o_intr_ret    (o_intr_ret)
    );

    flush_fsm flush_fsm_inst (
        .clk            (clk),
        .reset          (reset),
        .i_jmp_chk      (o_jmp_chk),
        .i_stall        (o_stall_d),            // Stalled jump waits in decode
        .i_branch_taken (i_branch_taken),
        .o_flush_f      (o_flush_f),
        .o_flush_d      (o_flush_d),
        .o_flush_ex     (o_flush_ex)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module pipeline_control_tb -f filelist.f \
    -o pipeline_control_sim > sim.log 2>&1 \
    && ./obj_dir/pipeline_control_sim >> sim.log 2>&1 \
    || { echo "Build or simulation error, see sim.log"; exit 1; }
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== sim/pipeline_control_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_control_tb;

    import cpu_ctrl_pkg::*;

    localparam logic [31:0] SEED      = 32'h336f_a9e3;
    localparam instr_t      NOP_INSTR = 8'h00;
    localparam int          MAX_CYCLES = 400;  // Well above the length of all tests

    logic      clk;
    logic      reset;
    instr_t    instr;
    logic      branch_taken;
    logic      intr;
    logic      reg_write, mem_read, mem_write, sp_inc, sp_dec, store_pc, return_flags;
    alu_op_e   alu_op;
    flag_chg_e flag_change;
    reg_idx_t  reg_1, reg_2, wb_sel;
    opnd_src_e alu_src_a, alu_src_b;
    jmp_chk_e  jmp_chk;
    fwd_sel_e  fwd_a, fwd_b;
    logic      stall_f, stall_d, flush_f, flush_d, flush_ex;
    logic      intr_ack, intr_active, intr_ret;
    logic [31:0] lfsr;
    int        errors;
    int        checks;
    int        tests;
    int        cycles;

    pipeline_control pipeline_control_inst (
        .clk (clk), .reset (reset), .i_instr (instr),
        .i_branch_taken (branch_taken), .i_intr (intr),
        .o_reg_write (reg_write), .o_mem_read (mem_read), .o_mem_write (mem_write),
        .o_alu_op (alu_op), .o_flag_change (flag_change),
        .o_reg_1 (reg_1), .o_reg_2 (reg_2),
        .o_alu_src_a (alu_src_a), .o_alu_src_b (alu_src_b), .o_wb_sel (wb_sel),
        .o_sp_inc (sp_inc), .o_sp_dec (sp_dec), .o_jmp_chk (jmp_chk),
        .o_store_pc (store_pc), .o_return_flags (return_flags),
        .o_forward_src_a (fwd_a), .o_forward_src_b (fwd_b),
        .o_stall_f (stall_f), .o_stall_d (stall_d),
        .o_flush_f (flush_f), .o_flush_d (flush_d), .o_flush_ex (flush_ex),
        .o_intr_ack (intr_ack), .o_intr_active (intr_active), .o_intr_ret (intr_ret)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, tests did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
    endfunction

    task automatic rand_reg(output reg_idx_t r);
        r = 2'd0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            r[i] = lfsr[0];
        end
    endtask

    function automatic instr_t encode(input opcode_e op, input reg_idx_t ra, input reg_idx_t rb);
        return {op, ra, rb};
    endfunction

    // Inputs change 1 ns after the edge and checks follow 2 ns later
    task automatic drive(input instr_t v, input logic br, input logic irq);
        @(posedge clk);
        #1;
        instr        = v;
        branch_taken = br;
        intr         = irq;
        #2;
    endtask

    task automatic drain_pipe();
        repeat (3) drive(NOP_INSTR, 1'b0, 1'b0);  // Empties EX, MEM, WB
    endtask

    task automatic report(input string name, input int e0);
        tests++;
        if (errors == e0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - e0);
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e exp, input alu_op_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %s got %s (%0d)", $time, name,
                     exp.name(), act.name(), act);
        end
    endtask

    task automatic check_src(input string name, input opnd_src_e exp, input opnd_src_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_fwd(input string name, input fwd_sel_e exp, input fwd_sel_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %s got %s (%0d)", $time, name,
                     exp.name(), act.name(), act);
        end
    endtask

    task automatic check_flag(input string name, input flag_chg_e exp, input flag_chg_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %s got %s (%0d)", $time, name,
                     exp.name(), act.name(), act);
        end
    endtask

    task automatic check_jmp(input string name, input jmp_chk_e exp, input jmp_chk_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: expected %s got %s (%0d)", $time, name,
                     exp.name(), act.name(), act);
        end
    endtask

    task automatic expect_decode(input alu_op_e op, input flag_chg_e f, input logic wr,
                                 input reg_idx_t wb, input reg_idx_t r1, input reg_idx_t r2,
                                 input logic inc, input logic dec, input jmp_chk_e j);
        check_alu_op("alu_op", op, alu_op);
        check_flag("flag_change", f, flag_change);
        check_bit("reg_write", wr, reg_write);
        check_reg("wb_sel", wb, wb_sel);
        check_reg("reg_1", r1, reg_1);
        check_reg("reg_2", r2, reg_2);
        check_bit("sp_inc", inc, sp_inc);
        check_bit("sp_dec", dec, sp_dec);
        check_jmp("jmp_chk", j, jmp_chk);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic reset_state();
        int e0;
        e0 = errors;
        drive(NOP_INSTR, 1'b0, 1'b0);
        check_bit("stall_f", 1'b0, stall_f);
        check_bit("stall_d", 1'b0, stall_d);
        check_bit("flush_f", 1'b0, flush_f);
        check_bit("flush_d", 1'b0, flush_d);
        check_bit("flush_ex", 1'b0, flush_ex);
        check_bit("intr_ack", 1'b0, intr_ack);
        check_bit("intr_active", 1'b0, intr_active);
        check_bit("intr_ret", 1'b0, intr_ret);
        check_fwd("forward_src_a", FWD_NONE, fwd_a);
        check_fwd("forward_src_b", FWD_NONE, fwd_b);
        report("reset", e0);
    endtask

    task automatic decode_ops();
        int       e0;
        reg_idx_t a;
        reg_idx_t b;
        e0 = errors;
        drain_pipe();
        rand_reg(a);
        rand_reg(b);
        drive(encode(OPC_ADD, a, b), 1'b0, 1'b0);
        expect_decode(ADD, FLG_ALL, 1'b1, a, a, b, 1'b0, 1'b0, JC_NONE);
        check_src("alu_src_a", SRC_REG, alu_src_a);
        check_src("alu_src_b", SRC_REG, alu_src_b);
        drive(encode(OPC_SUB, b, a), 1'b0, 1'b0);
        expect_decode(SUB, FLG_ALL, 1'b1, b, b, a, 1'b0, 1'b0, JC_NONE);
        drive(encode(OPC_AND, a, b), 1'b0, 1'b0);
        expect_decode(AND, FLG_ZN, 1'b1, a, a, b, 1'b0, 1'b0, JC_NONE);
        drive(encode(OPC_UNARY, 2'd2, b), 1'b0, 1'b0);     // INC
        expect_decode(INC, FLG_ALL, 1'b1, b, 2'd0, b, 1'b0, 1'b0, JC_NONE);
        check_src("alu_src_a", SRC_IMM, alu_src_a);
        check_src("alu_src_b", SRC_REG, alu_src_b);
        drive(encode(OPC_UNARY, 2'd0, a), 1'b0, 1'b0);     // NOT
        expect_decode(NOT, FLG_ZN, 1'b1, a, 2'd0, a, 1'b0, 1'b0, JC_NONE);
        drive(encode(OPC_STACK, 2'd0, b), 1'b0, 1'b0);     // PUSH
        expect_decode(MOV_A, FLG_NONE, 1'b0, 2'd0, SP_REG, b, 1'b0, 1'b1, JC_NONE);
        check_bit("mem_write", 1'b1, mem_write);
        drive(encode(OPC_STACK, 2'd1, a), 1'b0, 1'b0);     // POP
        expect_decode(MOV_A, FLG_NONE, 1'b1, a, SP_REG, 2'd0, 1'b1, 1'b0, JC_NONE);
        check_bit("mem_read", 1'b1, mem_read);
        check_src("alu_src_b", SRC_IMM, alu_src_b);
        drive(encode(OPC_LOOP, a, b), 1'b0, 1'b0);
        expect_decode(DEC_A, FLG_NONE, 1'b1, a, a, b, 1'b0, 1'b0, JC_LOOP);
        drive(encode(OPC_JUMP, 2'd1, b), 1'b0, 1'b0);      // CALL
        expect_decode(MOV_A, FLG_NONE, 1'b0, 2'd0, SP_REG, b, 1'b0, 1'b1, JC_JMP);
        check_bit("store_pc", 1'b1, store_pc);
        check_bit("mem_write", 1'b1, mem_write);
        drive(encode(OPC_JUMP, 2'd3, a), 1'b0, 1'b0);      // RTI
        expect_decode(MOV_A, FLG_NONE, 1'b0, 2'd0, SP_REG, 2'd0, 1'b1, 1'b0, JC_RET);
        check_bit("return_flags", 1'b1, return_flags);
        check_bit("mem_read", 1'b1, mem_read);
        for (int op = 12; op < 15; op++) begin                // Dropped formats
            rand_reg(a);
            drive({op[3:0], a, b}, 1'b0, 1'b0);
            expect_decode(MOV_A, FLG_NONE, 1'b0, 2'd0, 2'd0, 2'd0, 1'b0, 1'b0, JC_NONE);
            check_bit("mem_write", 1'b0, mem_write);
            check_bit("mem_read", 1'b0, mem_read);
        end
        report("decode", e0);
    endtask

    task automatic forward_paths();
        int       e0;
        reg_idx_t x;
        reg_idx_t y;
        fwd_sel_e exp;
        fwd_sel_e exp_a;
        e0 = errors;
        for (int n = 0; n < 4; n++) begin
            drain_pipe();
            rand_reg(x);
            rand_reg(y);
            drive(encode(OPC_ADD, x, x), 1'b0, 1'b0);      // Producer writes x
            repeat (n) drive(NOP_INSTR, 1'b0, 1'b0);
            drive(encode(OPC_ADD, y, x), 1'b0, 1'b0);
            case (n)
                0:       exp = FWD_ALU;
                1:       exp = FWD_MEM;
                2:       exp = FWD_WB;
                default: exp = FWD_NONE;
            endcase
            exp_a = (y == x) ? exp : FWD_NONE;             // Operand A reads y
            check_fwd("forward_src_a", exp_a, fwd_a);
            check_fwd("forward_src_b", exp, fwd_b);
            check_bit("stall_d", 1'b0, stall_d);
        end
        report("forwarding", e0);
    endtask

    task automatic load_use_stall();
        int       e0;
        reg_idx_t x;
        reg_idx_t y;
        e0 = errors;
        drain_pipe();
        rand_reg(x);
        rand_reg(y);
        drive(encode(OPC_STACK, 2'd1, x), 1'b0, 1'b0);     // POP x
        drive(encode(OPC_ADD, y, x), 1'b0, 1'b0);
        check_bit("stall_f", 1'b1, stall_f);
        check_bit("stall_d", 1'b1, stall_d);
        drive(encode(OPC_ADD, y, x), 1'b0, 1'b0);          // ADD held in decode
        check_bit("stall_d", 1'b0, stall_d);
        check_fwd("forward_src_b", FWD_MEM, fwd_b);
        report("load_use", e0);
    endtask

    task automatic interrupt_entry();
        int e0;
        e0 = errors;
        drain_pipe();
        for (int c = 0; c < 7; c++) begin
            drive(NOP_INSTR, 1'b0, c < 4);                   // Level held 4 cycles
            check_bit("intr_ack", c == 1, intr_ack);
            check_bit("intr_active", c >= 2 && c <= 4, intr_active);
            check_bit("intr_ret", c == 5, intr_ret);
            if (c == 1) begin
                check_bit("sp_dec", 1'b1, sp_dec);
                check_bit("mem_write", 1'b1, mem_write);
                check_reg("reg_1", SP_REG, reg_1);
                check_src("alu_src_b", SRC_PC, alu_src_b);
            end
        end
        report("interrupt", e0);
    endtask

    // Flush expected at cycle "at" after the jump or never when at is -1
    task automatic flush_case(input string name, input instr_t j, input logic br,
                              input int at, input logic with_ex);
        int e0;
        e0 = errors;
        drain_pipe();
        for (int c = 0; c < 4; c++) begin
            drive((c == 0) ? j : NOP_INSTR, br && c == 1, 1'b0);  // Branch result in EX
            check_bit("flush_f", c == at, flush_f);
            check_bit("flush_d", c == at, flush_d);
            check_bit("flush_ex", with_ex && c == at, flush_ex);
        end
        report(name, e0);
    endtask

    initial begin
        reset        = 1'b1;
        instr        = NOP_INSTR;
        branch_taken = 1'b0;
        intr         = 1'b0;
        lfsr         = SEED;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        cycles       = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_state();
        decode_ops();
        forward_paths();
        load_use_stall();
        interrupt_entry();
        flush_case("flush_jmp", encode(OPC_JUMP, 2'd0, 2'd1), 1'b0, 1, 1'b0);
        flush_case("flush_ret", encode(OPC_JUMP, 2'd2, 2'd0), 1'b0, 2, 1'b1);
        flush_case("flush_jz_taken", encode(OPC_JCOND, 2'd0, 2'd2), 1'b1, 1, 1'b0);
        flush_case("flush_jz_not_taken", encode(OPC_JCOND, 2'd0, 2'd2), 1'b0, -1, 1'b0);
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
